//--- src/wq_mgr_pkg.sv
`default_nettype none

package wq_mgr_pkg;

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////

  // position in the send queue ring
  typedef logic [31:0]  wq_idx_t;
  // host byte address
  typedef logic [63:0]  addr_t;
  // narrowed element, holds every field in use
  typedef logic [255:0] wqe_t;
  typedef logic [31:0]  sq_len_t;
  typedef logic [2:0]   mtu_code_t;
  typedef logic [7:0]   qp_idx_t;
  typedef logic [31:0]  qp_conf_t;
  typedef logic [7:0]   sq_opcode_t;

  ////////////////////////////////////////////////////////////
  // constants
  ////////////////////////////////////////////////////////////

  // one element per 64-byte slot
  localparam int unsigned WQE_BYTES      = 64;
  localparam int unsigned WQE_ADDR_SHIFT = 6;

  // mtu in bytes is 256 << code
  localparam int unsigned MTU_BASE     = 256;
  // codes above this one are illegal
  localparam int unsigned MTU_CODE_MAX = 4;

  // queue pair config bits
  localparam int unsigned QP_EN_BIT    = 0;
  localparam int unsigned MTU_CODE_LSB = 8;

  // element field offsets
  localparam int unsigned WQE_RVADDR_LSB = 160;
  localparam int unsigned WQE_OP_LSB     = 128;
  localparam int unsigned WQE_LEN_LSB    = 96;

  // element opcodes
  localparam sq_opcode_t WQE_OP_WRITE = 8'h00;
  localparam sq_opcode_t WQE_OP_READ  = 8'h04;

  // send queue command opcodes
  localparam sq_opcode_t SQ_OP_WR_FIRST  = 8'h06;
  localparam sq_opcode_t SQ_OP_WR_MIDDLE = 8'h07;
  localparam sq_opcode_t SQ_OP_WR_LAST   = 8'h08;
  localparam sq_opcode_t SQ_OP_WR_ONLY   = 8'h0a;
  localparam sq_opcode_t SQ_OP_RD        = 8'h0c;

endpackage

`default_nettype wire

//--- src/wq_if.sv
`default_nettype none

// accepted queue pair context, held while the controller is busy
interface qp_ctx_if import wq_mgr_pkg::*; ();
  logic    qp_start;
  sq_len_t mtu;
  addr_t   sq_base;
  wq_idx_t prod_idx;
  wq_idx_t first_idx;
  addr_t   pd_vaddr;
  logic    busy;

  modport ctx   (output qp_start, mtu, sq_base, prod_idx, first_idx, pd_vaddr,
                 input busy);
  modport ctrl  (input qp_start, prod_idx, first_idx, output busy);
  modport fetch (input sq_base);
  modport seg   (input mtu, pd_vaddr);
endinterface

// one element fetch, wqe stays valid from done until the next start
interface wqe_fetch_if import wq_mgr_pkg::*; ();
  logic    start;
  wq_idx_t wq_idx;
  logic    done;
  wqe_t    wqe;

  modport ctrl  (output start, wq_idx, input done);
  modport fetch (input start, wq_idx, output done, wqe);
  modport seg   (input wqe);
endinterface

// segmentation of the element just fetched
interface sq_seg_if ();
  logic start;
  logic done;

  modport ctrl (output start, input done);
  modport seg  (input start, output done);
endinterface

`default_nettype wire

//--- src/wq_qp_ctx.sv
`default_nettype none

module wq_qp_ctx import wq_mgr_pkg::*; (
  input  logic     axil_aclk_i,
  input  logic     rstn_i,
  input  qp_idx_t  qp_idx_i,
  input  qp_conf_t qp_conf_i,
  input  addr_t    sq_base_i,
  input  wq_idx_t  sq_prod_idx_i,
  input  wq_idx_t  cq_head_i,
  input  addr_t    pd_vaddr_i,
  qp_ctx_if.ctx    ctx
);

  // captured context
  qp_idx_t   cap_qp_idx;
  wq_idx_t   cap_prod_idx;
  wq_idx_t   cap_first_idx;
  addr_t     cap_sq_base;
  addr_t     cap_pd_vaddr;
  logic      cap_en;
  mtu_code_t cap_code;

  logic    chk_q;
  logic    start_q;
  sq_len_t mtu_q;
  logic    change;

  // new work when qp number or producer index moved
  // held off while the controller runs or a check is pending
  assign change = (qp_idx_i != cap_qp_idx || sq_prod_idx_i != cap_prod_idx) &&
                  !ctx.busy && !chk_q && !start_q;

  always_ff @(posedge axil_aclk_i, negedge rstn_i) begin
    if (!rstn_i) begin
      cap_qp_idx    <= '0;
      cap_prod_idx  <= '0;
      cap_first_idx <= '0;
      cap_sq_base   <= '0;
      cap_pd_vaddr  <= '0;
      cap_en        <= 1'b0;
      cap_code      <= '0;
      chk_q         <= 1'b0;
      start_q       <= 1'b0;
      mtu_q         <= '0;
    end else begin
      start_q <= 1'b0;
      chk_q   <= 1'b0;
      if (change) begin
        cap_qp_idx    <= qp_idx_i;
        cap_prod_idx  <= sq_prod_idx_i;
        cap_first_idx <= cq_head_i;
        cap_sq_base   <= sq_base_i;
        cap_pd_vaddr  <= pd_vaddr_i;
        cap_en        <= qp_conf_i[QP_EN_BIT];
        cap_code      <= qp_conf_i[MTU_CODE_LSB +: $bits(mtu_code_t)];
        chk_q         <= 1'b1;
      end
      // check cycle, a failed context just stays captured
      if (chk_q && cap_en && cap_code <= MTU_CODE_MAX) begin
        mtu_q   <= sq_len_t'(MTU_BASE) << cap_code;
        start_q <= 1'b1;
      end
    end
  end

  assign ctx.qp_start  = start_q;
  assign ctx.mtu       = mtu_q;
  assign ctx.sq_base   = cap_sq_base;
  assign ctx.prod_idx  = cap_prod_idx;
  assign ctx.first_idx = cap_first_idx;
  assign ctx.pd_vaddr  = cap_pd_vaddr;

endmodule

`default_nettype wire

//--- src/wq_ctrl.sv
`default_nettype none

module wq_ctrl import wq_mgr_pkg::*; (
  input  logic      axil_aclk_i,
  input  logic      rstn_i,
  qp_ctx_if.ctrl    ctx,
  wqe_fetch_if.ctrl fetch,
  sq_seg_if.ctrl    seg,
  output wq_idx_t   cq_head_o
);

  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    SEGMENT,
    ADVANCE
  } ctrl_state_t;

  ctrl_state_t state_q;
  wq_idx_t     wq_idx_q;
  wq_idx_t     cq_head_q;
  logic        busy_q;
  logic        fetch_start_q;
  logic        seg_start_q;

  ////////////////////////////////////////////////////////////
  // element loop
  ////////////////////////////////////////////////////////////

  always_ff @(posedge axil_aclk_i, negedge rstn_i) begin
    if (!rstn_i) begin
      state_q       <= IDLE;
      wq_idx_q      <= '0;
      cq_head_q     <= '0;
      busy_q        <= 1'b0;
      fetch_start_q <= 1'b0;
      seg_start_q   <= 1'b0;
    end else begin
      fetch_start_q <= 1'b0;
      seg_start_q   <= 1'b0;
      case (state_q)
        IDLE: begin
          if (ctx.qp_start) begin
            wq_idx_q  <= ctx.first_idx;
            cq_head_q <= ctx.first_idx;
            // nothing queued means we stay idle
            if (ctx.first_idx < ctx.prod_idx) begin
              busy_q        <= 1'b1;
              fetch_start_q <= 1'b1;
              state_q       <= FETCH;
            end
          end
        end
        FETCH: begin
          if (fetch.done) begin
            seg_start_q <= 1'b1;
            state_q     <= SEGMENT;
          end
        end
        SEGMENT: begin
          // element finished
          if (seg.done) begin
            wq_idx_q  <= wq_idx_q + 1'b1;
            cq_head_q <= cq_head_q + 1'b1;
            state_q   <= ADVANCE;
          end
        end
        ADVANCE: begin
          if (wq_idx_q < ctx.prod_idx) begin
            fetch_start_q <= 1'b1;
            state_q       <= FETCH;
          end else begin
            busy_q  <= 1'b0;
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  assign ctx.busy     = busy_q;
  assign fetch.start  = fetch_start_q;
  assign fetch.wq_idx = wq_idx_q;
  assign seg.start    = seg_start_q;
  assign cq_head_o    = cq_head_q;

  // the capture side must hold off while a queue pair is running
  a_no_start_busy: assert property (
    @(posedge axil_aclk_i) disable iff (!rstn_i)
    ctx.qp_start |-> !ctx.busy && state_q == IDLE
  );

endmodule

`default_nettype wire

//--- src/wq_fetch.sv
`default_nettype none

module wq_fetch import wq_mgr_pkg::*; (
  input  logic       axil_aclk_i,
  input  logic       rstn_i,
  qp_ctx_if.fetch    ctx,
  wqe_fetch_if.fetch fetch,
  output addr_t      araddr_o,
  output logic       arvalid_o,
  input  logic       arready_i,
  input  logic       rvalid_i,
  input  wqe_t       rdata_i,
  input  logic       rlast_i,
  output logic       rready_o
);

  typedef enum logic [1:0] {
    AR_IDLE,
    AR_VALID,
    R_WAIT
  } fetch_state_t;

  fetch_state_t state_q;
  wqe_t         wqe_q;
  logic         done_q;

  always_ff @(posedge axil_aclk_i, negedge rstn_i) begin
    if (!rstn_i) begin
      state_q <= AR_IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        AR_IDLE: begin
          if (fetch.start) state_q <= AR_VALID;
        end
        AR_VALID: begin
          if (arready_i) state_q <= R_WAIT;
        end
        R_WAIT: begin
          if (rvalid_i) begin
            done_q  <= 1'b1;
            state_q <= AR_IDLE;
          end
        end
        default: state_q <= AR_IDLE;
      endcase
    end
  end

  // beat register
  always_ff @(posedge axil_aclk_i) begin
    if (state_q == R_WAIT && rvalid_i) wqe_q <= rdata_i;
  end

  // slot address, base plus index * 64
  // base and index both hold while the element is in flight
  assign araddr_o   = ctx.sq_base + (addr_t'(fetch.wq_idx) << WQE_ADDR_SHIFT);
  assign arvalid_o  = (state_q == AR_VALID);
  assign rready_o   = (state_q == R_WAIT);
  assign fetch.done = done_q;
  assign fetch.wqe  = wqe_q;

  // single beat per element
  a_rlast: assert property (
    @(posedge axil_aclk_i) disable iff (!rstn_i)
    rvalid_i && rready_o |-> rlast_i
  );

  a_ar_stable: assert property (
    @(posedge axil_aclk_i) disable iff (!rstn_i)
    arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o)
  );

endmodule

`default_nettype wire

//--- src/wq_segmenter.sv
`default_nettype none

module wq_segmenter import wq_mgr_pkg::*; (
  input  logic       axil_aclk_i,
  input  logic       rstn_i,
  qp_ctx_if.seg      ctx,
  wqe_fetch_if.seg   wqe,
  sq_seg_if.seg      seg,
  output logic       sq_valid_o,
  input  logic       sq_ready_i,
  output sq_opcode_t sq_opcode_o,
  output sq_len_t    sq_len_o,
  output addr_t      sq_lvaddr_o,
  output addr_t      sq_rvaddr_o,
  output logic       sq_last_o
);

  // write segments loop in SEG_EMIT, a read is one command in SEG_VALID
  typedef enum logic [1:0] {
    SEG_IDLE,
    SEG_EMIT,
    SEG_VALID
  } seg_state_t;

  seg_state_t state_q;
  sq_len_t    rem_q;
  addr_t      laddr_q;
  addr_t      raddr_q;
  logic       first_q;
  logic       done_q;

  sq_opcode_t wqe_op;
  logic       last_seg;
  logic       accept;

  assign wqe_op   = wqe.wqe[WQE_OP_LSB +: $bits(sq_opcode_t)];
  assign accept   = sq_valid_o && sq_ready_i;
  // final segment once the rest fits in one mtu
  assign last_seg = (rem_q <= ctx.mtu);

  ////////////////////////////////////////////////////////////
  // segment state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge axil_aclk_i, negedge rstn_i) begin
    if (!rstn_i) begin
      state_q <= SEG_IDLE;
      first_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        SEG_IDLE: begin
          if (seg.start) begin
            first_q <= 1'b1;
            if (wqe_op == WQE_OP_WRITE) state_q <= SEG_EMIT;
            else if (wqe_op == WQE_OP_READ) state_q <= SEG_VALID;
            // unsupported opcode, nothing to send
            else done_q <= 1'b1;
          end
        end
        SEG_EMIT: begin
          if (accept) begin
            first_q <= 1'b0;
            if (last_seg) begin
              done_q  <= 1'b1;
              state_q <= SEG_IDLE;
            end
          end
        end
        SEG_VALID: begin
          if (accept) begin
            done_q  <= 1'b1;
            state_q <= SEG_IDLE;
          end
        end
        default: state_q <= SEG_IDLE;
      endcase
    end
  end

  // remaining length and both addresses
  always_ff @(posedge axil_aclk_i) begin
    if (state_q == SEG_IDLE && seg.start) begin
      rem_q   <= wqe.wqe[WQE_LEN_LSB +: $bits(sq_len_t)];
      laddr_q <= ctx.pd_vaddr;
      raddr_q <= wqe.wqe[WQE_RVADDR_LSB +: $bits(addr_t)];
    end else if (state_q == SEG_EMIT && accept && !last_seg) begin
      rem_q   <= rem_q - ctx.mtu;
      laddr_q <= laddr_q + addr_t'(ctx.mtu);
      raddr_q <= raddr_q + addr_t'(ctx.mtu);
    end
  end

  ////////////////////////////////////////////////////////////
  // command fields
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (state_q == SEG_VALID) sq_opcode_o = SQ_OP_RD;
    else if (first_q) sq_opcode_o = last_seg ? SQ_OP_WR_ONLY : SQ_OP_WR_FIRST;
    else sq_opcode_o = last_seg ? SQ_OP_WR_LAST : SQ_OP_WR_MIDDLE;
  end

  assign sq_valid_o  = (state_q != SEG_IDLE);
  assign sq_len_o    = (state_q == SEG_EMIT && !last_seg) ? ctx.mtu : rem_q;
  assign sq_lvaddr_o = laddr_q;
  assign sq_rvaddr_o = raddr_q;
  assign sq_last_o   = (state_q == SEG_VALID) || last_seg;
  assign seg.done    = done_q;

  // also needs mtu held by the context side
  a_cmd_stable: assert property (
    @(posedge axil_aclk_i) disable iff (!rstn_i)
    sq_valid_o && !sq_ready_i |=> sq_valid_o &&
      $stable({sq_opcode_o, sq_len_o, sq_lvaddr_o, sq_rvaddr_o, sq_last_o})
  );

endmodule

`default_nettype wire

//--- src/wq_manager_top.sv
`default_nettype none

module wq_manager_top import wq_mgr_pkg::*; (
  input  logic       axil_aclk_i,
  input  logic       rstn_i,

  // queue pair registers
  input  qp_idx_t    qp_idx_i,
  input  qp_conf_t   qp_conf_i,
  input  addr_t      sq_base_i,
  input  wq_idx_t    sq_prod_idx_i,
  input  wq_idx_t    cq_head_i,
  input  addr_t      pd_vaddr_i,
  output wq_idx_t    cq_head_o,

  // axi read, element fetch
  output addr_t      araddr_o,
  output logic       arvalid_o,
  input  logic       arready_i,
  input  logic       rvalid_i,
  input  wqe_t       rdata_i,
  input  logic       rlast_i,
  output logic       rready_o,

  // send queue commands
  output logic       sq_valid_o,
  input  logic       sq_ready_i,
  output sq_opcode_t sq_opcode_o,
  output sq_len_t    sq_len_o,
  output addr_t      sq_lvaddr_o,
  output addr_t      sq_rvaddr_o,
  output logic       sq_last_o
);

  qp_ctx_if    ctx_if ();
  wqe_fetch_if fetch_if ();
  sq_seg_if    seg_if ();

  wq_qp_ctx u_qp_ctx (
    .axil_aclk_i   (axil_aclk_i),
    .rstn_i        (rstn_i),
    .qp_idx_i      (qp_idx_i),
    .qp_conf_i     (qp_conf_i),
    .sq_base_i     (sq_base_i),
    .sq_prod_idx_i (sq_prod_idx_i),
    .cq_head_i     (cq_head_i),
    .pd_vaddr_i    (pd_vaddr_i),
    .ctx           (ctx_if.ctx)
  );

  wq_ctrl u_ctrl (
    .axil_aclk_i (axil_aclk_i),
    .rstn_i      (rstn_i),
    .ctx         (ctx_if.ctrl),
    .fetch       (fetch_if.ctrl),
    .seg         (seg_if.ctrl),
    .cq_head_o   (cq_head_o)
  );

  wq_fetch u_fetch (
    .axil_aclk_i (axil_aclk_i),
    .rstn_i      (rstn_i),
    .ctx         (ctx_if.fetch),
    .fetch       (fetch_if.fetch),
    .araddr_o    (araddr_o),
    .arvalid_o   (arvalid_o),
    .arready_i   (arready_i),
    .rvalid_i    (rvalid_i),
    .rdata_i     (rdata_i),
    .rlast_i     (rlast_i),
    .rready_o    (rready_o)
  );

  wq_segmenter u_segmenter (
    .axil_aclk_i (axil_aclk_i),
    .rstn_i      (rstn_i),
    .ctx         (ctx_if.seg),
    .wqe         (fetch_if.seg),
    .seg         (seg_if.seg),
    .sq_valid_o  (sq_valid_o),
    .sq_ready_i  (sq_ready_i),
    .sq_opcode_o (sq_opcode_o),
    .sq_len_o    (sq_len_o),
    .sq_lvaddr_o (sq_lvaddr_o),
    .sq_rvaddr_o (sq_rvaddr_o),
    .sq_last_o   (sq_last_o)
  );

endmodule

`default_nettype wire

//--- test/tb_wq_axi_mem.sv
`default_nettype none

module tb_wq_axi_mem import wq_mgr_pkg::*; #(
  parameter int unsigned DEPTH     = 64,
  parameter int unsigned DELAY_MAX = 3
) (
  input  logic  clk_i,
  input  logic  rstn_i,
  input  addr_t araddr_i,
  input  logic  arvalid_i,
  output logic  arready_o,
  output logic  rvalid_o,
  output wqe_t  rdata_o,
  output logic  rlast_o,
  input  logic  rready_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // one element per 64-byte slot, loaded by the testbench
  wqe_t mem [DEPTH];

  // single beat responder, random gaps before arready and before the beat
  initial begin : responder
    addr_t       addr;
    int unsigned gap;
    arready_o = 1'b0;
    rvalid_o  = 1'b0;
    rlast_o   = 1'b0;
    rdata_o   = '0;
    forever begin
      @(negedge clk_i);
      if (rstn_i && arvalid_i) begin
        gap = $urandom % (DELAY_MAX + 1);
        repeat (gap) @(negedge clk_i);
        addr      = araddr_i;
        arready_o = 1'b1;
        @(negedge clk_i);
        arready_o = 1'b0;
        gap = $urandom % (DELAY_MAX + 1);
        repeat (gap) @(negedge clk_i);
        rdata_o  = mem[(addr >> WQE_ADDR_SHIFT) % DEPTH];
        rvalid_o = 1'b1;
        rlast_o  = 1'b1;
        // hold the beat until the DUT takes it
        do begin
          @(posedge clk_i);
        end while (!rready_i);
        @(negedge clk_i);
        rvalid_o = 1'b0;
        rlast_o  = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- test/tb_wq_manager.sv
`default_nettype none

module tb_wq_manager import wq_mgr_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned SEED          = 32'h8d2bdae9;
  localparam int unsigned MEM_DEPTH     = 64;
  localparam int unsigned MEM_DELAY_MAX = 3;
  localparam int unsigned STALL_MAX     = 3;
  localparam int unsigned REJECT_WAIT   = 12;
  localparam int unsigned SETTLE_WAIT   = 16;

  // element and command opcodes as the queue format defines them
  localparam sq_opcode_t OP_WRITE    = 8'h00;
  localparam sq_opcode_t OP_READ     = 8'h04;
  localparam sq_opcode_t OP_BAD      = 8'h02;
  localparam sq_opcode_t EXP_FIRST   = 8'h06;
  localparam sq_opcode_t EXP_MIDDLE  = 8'h07;
  localparam sq_opcode_t EXP_LAST    = 8'h08;
  localparam sq_opcode_t EXP_ONLY    = 8'h0a;
  localparam sq_opcode_t EXP_RD      = 8'h0c;

  typedef struct packed {
    sq_opcode_t op;
    sq_len_t    len;
    addr_t      lva;
    addr_t      rva;
    logic       last;
  } cmd_t;

  logic       clk = 1'b0;
  logic       rstn;
  qp_idx_t    qp_idx;
  qp_conf_t   qp_conf;
  addr_t      sq_base;
  wq_idx_t    prod_idx;
  wq_idx_t    head_in;
  addr_t      pd_vaddr;
  wq_idx_t    cq_head;
  addr_t      araddr;
  logic       arvalid;
  logic       arready;
  logic       rvalid;
  wqe_t       rdata;
  logic       rlast;
  logic       rready;
  logic       sq_valid;
  logic       sq_ready;
  sq_opcode_t sq_opcode;
  sq_len_t    sq_len;
  addr_t      sq_lvaddr;
  addr_t      sq_rvaddr;
  logic       sq_last;

  cmd_t        exp_q[$];
  addr_t       ar_exp_q[$];
  addr_t       base;
  wq_idx_t     head;
  int unsigned cmd_count   = 0;
  int unsigned ar_count    = 0;
  int unsigned cycles      = 0;
  int unsigned cycle_limit = 32;

  wq_manager_top u_dut (
    .axil_aclk_i (clk), .rstn_i (rstn),
    .qp_idx_i (qp_idx), .qp_conf_i (qp_conf), .sq_base_i (sq_base),
    .sq_prod_idx_i (prod_idx), .cq_head_i (head_in), .pd_vaddr_i (pd_vaddr),
    .cq_head_o (cq_head),
    .araddr_o (araddr), .arvalid_o (arvalid), .arready_i (arready),
    .rvalid_i (rvalid), .rdata_i (rdata), .rlast_i (rlast), .rready_o (rready),
    .sq_valid_o (sq_valid), .sq_ready_i (sq_ready), .sq_opcode_o (sq_opcode),
    .sq_len_o (sq_len), .sq_lvaddr_o (sq_lvaddr), .sq_rvaddr_o (sq_rvaddr),
    .sq_last_o (sq_last)
  );

  tb_wq_axi_mem #(.DEPTH (MEM_DEPTH), .DELAY_MAX (MEM_DELAY_MAX)) u_mem (
    .clk_i (clk), .rstn_i (rstn), .araddr_i (araddr), .arvalid_i (arvalid),
    .arready_o (arready), .rvalid_o (rvalid), .rdata_o (rdata), .rlast_o (rlast),
    .rready_i (rready)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
    assert (got === want) else begin
      $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, want);
      $display("FAIL: see errors above");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic require(input logic ok, input string what);
    assert (ok) else begin
      $display("%0t %s", $time, what);
      $display("FAIL: see errors above");
      $fatal(1, "stopped at the first failure");
    end
  endtask

  function automatic addr_t random_addr();
    return {$urandom, $urandom};
  endfunction

  function automatic int unsigned slot_of(input addr_t a);
    return int'((a >> 6) % MEM_DEPTH);
  endfunction

  // random noise outside the enable bit and the mtu field
  function automatic qp_conf_t conf_word(input logic en, input int unsigned code);
    qp_conf_t c;
    c       = $urandom;
    c[10:8] = code[2:0];
    c[0]    = en;
    return c;
  endfunction

  // expected commands for one element, returns how many
  function automatic int unsigned wq_expect(input wqe_t wqe, input int unsigned code,
                                            input addr_t pd);
    sq_opcode_t  op;
    sq_len_t     mtu;
    sq_len_t     rem;
    addr_t       lva;
    addr_t       rva;
    int unsigned n;
    op  = wqe[135:128];
    rem = wqe[127:96];
    rva = wqe[223:160];
    lva = pd;
    mtu = 32'd256 << code;
    n   = 0;
    if (op == OP_READ) begin
      exp_q.push_back('{EXP_RD, rem, lva, rva, 1'b1});
      n = 1;
    end else if (op == OP_WRITE) begin
      while (rem > mtu) begin
        exp_q.push_back('{(n == 0) ? EXP_FIRST : EXP_MIDDLE, mtu, lva, rva, 1'b0});
        rem = rem - mtu;
        lva = lva + mtu;
        rva = rva + mtu;
        n++;
      end
      exp_q.push_back('{(n == 0) ? EXP_ONLY : EXP_LAST, rem, lva, rva, 1'b1});
      n++;
    end
    return n;
  endfunction

  task automatic put_wqe(input int unsigned pos, input sq_opcode_t op, input sq_len_t len);
    wqe_t        w;
    int unsigned k;
    // unused fields carry random filler
    for (k = 0; k < 8; k++) w[k*32 +: 32] = $urandom;
    w[WQE_OP_LSB +: 8]      = op;
    w[WQE_LEN_LSB +: 32]    = len;
    w[WQE_RVADDR_LSB +: 64] = random_addr();
    u_mem.mem[slot_of(base + addr_t'(head + pos) * 64)] = w;
  endtask

  task automatic apply_context(input qp_idx_t qp, input qp_conf_t conf, input addr_t pd,
                               input wq_idx_t prod);
    @(negedge clk);
    qp_idx   = qp;
    qp_conf  = conf;
    sq_base  = base;
    pd_vaddr = pd;
    head_in  = head;
    prod_idx = prod;
  endtask

  task automatic process_queue(input qp_idx_t qp, input int unsigned code,
                               input int unsigned n);
    addr_t       pd;
    addr_t       a;
    int unsigned segs;
    int unsigned i;
    pd = random_addr();
    for (i = 0; i < n; i++) begin
      a = base + addr_t'(head + i) * 64;
      ar_exp_q.push_back(a);
      segs = wq_expect(u_mem.mem[slot_of(a)], code, pd);
      cycle_limit = cycle_limit + 2 * (2 * MEM_DELAY_MAX + segs * (STALL_MAX + 1) + 8);
    end
    cycle_limit = cycle_limit + 2 * SETTLE_WAIT;
    apply_context(qp, conf_word(1'b1, code), pd, head + n);
    // last element retired
    while (cq_head != head + n) @(negedge clk);
    // quiet window, no further fetch or increment may follow
    repeat (SETTLE_WAIT) @(negedge clk);
    compare_value("cq_head_o", cq_head, head + n);
    require(exp_q.size() == 0, "a command expected for this queue never came out");
    require(ar_exp_q.size() == 0, "a fetch expected for this queue never happened");
    head = head + n;
  endtask

  task automatic expect_reject(input qp_idx_t qp, input logic en, input int unsigned code);
    int unsigned ar_before;
    int unsigned cmd_before;
    ar_before   = ar_count;
    cmd_before  = cmd_count;
    cycle_limit = cycle_limit + 2 * REJECT_WAIT;
    apply_context(qp, conf_word(en, code), random_addr(), head + 2);
    repeat (REJECT_WAIT) @(negedge clk);
    compare_value("ar handshakes", ar_count, ar_before);
    compare_value("sq commands", cmd_count, cmd_before);
    compare_value("cq_head_o", cq_head, head);
  endtask

  function automatic sq_opcode_t pick_op();
    case ($urandom % 3)
      0: return OP_WRITE;
      1: return OP_READ;
      default: return OP_BAD;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // monitors
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin : ar_monitor
    if (rstn && arvalid && arready) begin
      require(ar_exp_q.size() != 0, "read address issued when no fetch was expected");
      compare_value("araddr_o", araddr, ar_exp_q.pop_front());
      ar_count++;
    end
  end

  always @(posedge clk) begin : compare
    cmd_t want;
    if (rstn && sq_valid && sq_ready) begin
      require(exp_q.size() != 0, "a command came out when none was expected");
      want = exp_q.pop_front();
      compare_value("sq_opcode_o", sq_opcode, want.op);
      compare_value("sq_len_o", sq_len, want.len);
      compare_value("sq_lvaddr_o", sq_lvaddr, want.lva);
      compare_value("sq_rvaddr_o", sq_rvaddr, want.rva);
      compare_value("sq_last_o", sq_last, want.last);
      cmd_count++;
    end
  end

  always @(posedge clk) begin : watchdog
    cycles = cycles + 1;
    assert (cycles <= cycle_limit) else begin
      $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
      $display("FAIL: see errors above");
      $fatal(1, "run timed out");
    end
  end

  // random back-pressure, at most STALL_MAX idle cycles in a row
  initial begin : ready_drive
    int unsigned stall;
    sq_ready = 1'b0;
    forever begin
      @(negedge clk);
      stall    = $urandom % (STALL_MAX + 1);
      sq_ready = 1'b0;
      repeat (stall) @(negedge clk);
      sq_ready = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  initial begin : main
    sq_len_t     mtu;
    int unsigned code;
    int unsigned i;
    void'($urandom(SEED));
    rstn     = 1'b0;
    qp_idx   = '0;
    qp_conf  = '0;
    sq_base  = '0;
    prod_idx = '0;
    head_in  = '0;
    pd_vaddr = '0;
    head     = '0;
    base     = 64'h0000_0045_6780_0000;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;

    // one shorter than the mtu, one exactly the mtu
    put_wqe(0, OP_WRITE, 200);
    put_wqe(1, OP_WRITE, 256);
    process_queue(8'h11, 0, 2);

    // partial last segment, exact multiple and random length per code
    for (code = 0; code <= 4; code++) begin
      mtu  = 32'd256 << code;
      base = base + 64'h1_0040;
      put_wqe(0, OP_WRITE, 3 * mtu + 17);
      put_wqe(1, OP_WRITE, 2 * mtu);
      put_wqe(2, OP_WRITE, 1 + $urandom % (4 * mtu));
      process_queue(qp_idx_t'(8'h20 + code), code, 3);
    end

    // reads and unsupported opcodes
    put_wqe(0, OP_READ, 9000);
    put_wqe(1, 8'h01, 512);
    put_wqe(2, OP_READ, 64);
    put_wqe(3, 8'hff, 100);
    process_queue(8'h30, 2, 4);

    // enable clear, then illegal mtu codes
    expect_reject(8'h40, 1'b0, 1);
    expect_reject(8'h41, 1'b1, 5);
    expect_reject(8'h42, 1'b1, 7);

    // random mix after the rejects
    code = $urandom % 5;
    mtu  = 32'd256 << code;
    for (i = 0; i < 10; i++) put_wqe(i, pick_op(), 1 + $urandom % (3 * mtu));
    process_queue(8'h50, code, 10);

    if (exp_q.size() == 0 && ar_exp_q.size() == 0 && cq_head == head) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("commands or fetches still outstanding at the end of the run");
      $display("FAIL: see errors above");
      $fatal(1, "run ended with work outstanding");
    end
  end

endmodule

`default_nettype wire

//--- wq_manager.f
src/wq_mgr_pkg.sv
src/wq_if.sv
src/wq_qp_ctx.sv
src/wq_ctrl.sv
src/wq_fetch.sv
src/wq_segmenter.sv
src/wq_manager_top.sv
test/tb_wq_axi_mem.sv
test/tb_wq_manager.sv
